//--- common/lsu_pkg.sv
// core side load/store types

`include "obi_config.svh"

package lsu_pkg;

    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_e;

    // access width
    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,
        LSU_HALF = 2'd1,
        LSU_WORD = 2'd2
    } lsu_size_e;

    // request as issued by the core
    // store data is right-justified
    typedef struct packed {
        lsu_op_e                        op;
        lsu_size_e                      size;
        logic                           is_unsigned;
        logic [`OBI_ADDR_WIDTH-1:0]     addr;
        logic [`OBI_DATA_WIDTH-1:0]     wdata;
    } lsu_req_t;

    // response, qualified by a separate valid
    typedef struct packed {
        logic [`OBI_DATA_WIDTH-1:0]     rdata;
        logic                           err;
    } lsu_rsp_t;

    // aligned request handed to the bus master
    typedef struct packed {
        logic [`OBI_ADDR_WIDTH-1:0]     addr;
        logic                           we;
        logic [`OBI_DATA_WIDTH/8-1:0]   be;
        logic [`OBI_DATA_WIDTH-1:0]     wdata;
    } bus_req_t;

endpackage

//--- common/obi_config.svh
// obi subsystem parameters

`ifndef OBI_CONFIG_SVH
`define OBI_CONFIG_SVH

// byte address width on both the core and bus sides
`define OBI_ADDR_WIDTH 32

// bus data width, byte enables are this over 8
`define OBI_DATA_WIDTH 32

// memory depth in words
`define OBI_MEM_WORDS 256

// cycles gnt stays low while req is held
`define OBI_GNT_WAIT 2

`endif

//--- common/obi_pkg.sv
// obi bus types

`include "obi_config.svh"

package obi_pkg;

    // master to slave, payload valid while req is high
    typedef struct packed {
        logic                           req;
        logic [`OBI_ADDR_WIDTH-1:0]     addr;
        logic                           we;
        logic [`OBI_DATA_WIDTH/8-1:0]   be;
        logic [`OBI_DATA_WIDTH-1:0]     wdata;
    } obi_req_t;

    // slave to master
    // gnt is the address phase, rvalid/rdata/err the response phase
    typedef struct packed {
        logic                           gnt;
        logic                           rvalid;
        logic [`OBI_DATA_WIDTH-1:0]     rdata;
        logic                           err;
    } obi_rsp_t;

    // master fsm, one outstanding transaction
    typedef enum logic [1:0] {
        OBI_IDLE       = 2'd0,
        OBI_REQUESTING = 2'd1,
        OBI_WAITING    = 2'd2
    } obi_state_e;

endpackage

//--- logic/lsu_align.sv
// load/store alignment unit

`timescale 1ns/1ps
`include "obi_config.svh"

module lsu_align (
    input  logic                        clk,
    input  logic                        rst_n,
    // core side
    input  logic                        core_valid_i,
    output logic                        core_ready_o,
    input  lsu_pkg::lsu_req_t           core_req_i,
    output logic                        core_rsp_valid_o,
    output lsu_pkg::lsu_rsp_t           core_rsp_o,
    // bus master side
    output logic                        bus_valid_o,
    input  logic                        bus_ready_i,
    output lsu_pkg::bus_req_t           bus_req_o,
    input  logic                        bus_rvalid_i,
    input  logic [`OBI_DATA_WIDTH-1:0]  bus_rdata_i,
    input  logic                        bus_err_i
);

    localparam int DW   = `OBI_DATA_WIDTH;
    localparam int BEW  = `OBI_DATA_WIDTH / 8;
    localparam int OFFW = $clog2(BEW);

    logic [OFFW-1:0]     offset;
    logic [BEW-1:0]      be;
    logic                misaligned;
    logic                accept;

    // captured at acceptance, used when the load data returns
    logic [OFFW-1:0]     offset_q;
    lsu_pkg::lsu_size_e  size_q;
    logic                unsigned_q;

    logic [DW-1:0]       shifted;
    logic [DW-1:0]       load_data;

    logic                rsp_valid_q;
    lsu_pkg::lsu_rsp_t   rsp_q;

    assign offset = core_req_i.addr[OFFW-1:0];

    // byte enables and natural alignment check
    always_comb begin
        be         = '0;
        misaligned = 1'b0;
        case (core_req_i.size)
            lsu_pkg::LSU_BYTE: begin
                be = BEW'(1) << offset;
            end
            lsu_pkg::LSU_HALF: begin
                be         = BEW'(3) << offset;
                misaligned = offset[0];
            end
            lsu_pkg::LSU_WORD: begin
                be         = '1;
                misaligned = (offset != '0);
            end
            // unused size code, treat as bad access
            default: begin
                misaligned = 1'b1;
            end
        endcase
    end

    // master ready doubles as core ready
    assign core_ready_o = bus_ready_i;
    assign accept       = core_valid_i && bus_ready_i;
    // misaligned accesses never reach the bus
    assign bus_valid_o  = core_valid_i && !misaligned;

    assign bus_req_o.addr  = {core_req_i.addr[`OBI_ADDR_WIDTH-1:OFFW], {OFFW{1'b0}}};
    assign bus_req_o.we    = (core_req_i.op == lsu_pkg::LSU_STORE);
    assign bus_req_o.be    = be;
    // move store data up to its lanes
    assign bus_req_o.wdata = core_req_i.wdata << {offset, 3'b000};

    always_ff @(posedge clk) begin
        if (accept) begin
            offset_q   <= offset;
            size_q     <= core_req_i.size;
            unsigned_q <= core_req_i.is_unsigned;
        end
    end

    // bring the addressed lanes down to bit 0
    assign shifted = bus_rdata_i >> {offset_q, 3'b000};

    // sign or zero extension
    always_comb begin
        case (size_q)
            lsu_pkg::LSU_BYTE: begin
                load_data = {{(DW-8){shifted[7] & ~unsigned_q}}, shifted[7:0]};
            end
            lsu_pkg::LSU_HALF: begin
                load_data = {{(DW-16){shifted[15] & ~unsigned_q}}, shifted[15:0]};
            end
            default: begin
                load_data = shifted;
            end
        endcase
    end

    // response strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus_rvalid_i || (accept && misaligned);
        end
    end

    // response payload, errors return zero data
    always_ff @(posedge clk) begin
        if (bus_rvalid_i) begin
            rsp_q.rdata <= bus_err_i ? '0 : load_data;
            rsp_q.err   <= bus_err_i;
        end else if (accept && misaligned) begin
            rsp_q.rdata <= '0;
            rsp_q.err   <= 1'b1;
        end
    end

    assign core_rsp_valid_o = rsp_valid_q;
    assign core_rsp_o       = rsp_q;

endmodule

//--- logic/obi_subsys_top.sv
// load/store to memory subsystem

`timescale 1ns/1ps
`include "obi_config.svh"

module obi_subsys_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               core_valid_i,
    output logic               core_ready_o,
    input  lsu_pkg::lsu_req_t  core_req_i,
    output logic               core_rsp_valid_o,
    output lsu_pkg::lsu_rsp_t  core_rsp_o
);

    // alignment unit to master
    logic                        bus_valid;
    logic                        bus_ready;
    lsu_pkg::bus_req_t           bus_req;
    logic                        bus_rvalid;
    logic [`OBI_DATA_WIDTH-1:0]  bus_rdata;
    logic                        bus_err;

    // master to memory
    obi_pkg::obi_req_t           obi_req;
    obi_pkg::obi_rsp_t           obi_rsp;

    lsu_align u_lsu_align (
        .clk              (clk),
        .rst_n            (rst_n),
        .core_valid_i     (core_valid_i),
        .core_ready_o     (core_ready_o),
        .core_req_i       (core_req_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .bus_valid_o      (bus_valid),
        .bus_ready_i      (bus_ready),
        .bus_req_o        (bus_req),
        .bus_rvalid_i     (bus_rvalid),
        .bus_rdata_i      (bus_rdata),
        .bus_err_i        (bus_err)
    );

    obi_master u_obi_master (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (bus_valid),
        .req_ready_o (bus_ready),
        .req_i       (bus_req),
        .obi_req_o   (obi_req),
        .obi_rsp_i   (obi_rsp),
        .rsp_valid_o (bus_rvalid),
        .rsp_rdata_o (bus_rdata),
        .rsp_err_o   (bus_err)
    );

    obi_sram u_obi_sram (
        .clk       (clk),
        .rst_n     (rst_n),
        .obi_req_i (obi_req),
        .obi_rsp_o (obi_rsp)
    );

endmodule

//--- mem/obi_sram.sv
// obi slave memory model

`timescale 1ns/1ps
`include "obi_config.svh"

module obi_sram (
    input  logic               clk,
    input  logic               rst_n,
    input  obi_pkg::obi_req_t  obi_req_i,
    output obi_pkg::obi_rsp_t  obi_rsp_o
);

    localparam int DW   = `OBI_DATA_WIDTH;
    localparam int BEW  = `OBI_DATA_WIDTH / 8;
    localparam int OFFW = $clog2(BEW);
    localparam int IDXW = `OBI_ADDR_WIDTH - OFFW;
    localparam int MW   = $clog2(`OBI_MEM_WORDS);
    // room for the wait count even when it is zero
    localparam int CW   = $clog2(`OBI_GNT_WAIT + 2);

    logic [DW-1:0]    mem [`OBI_MEM_WORDS];

    logic [CW-1:0]    wait_cnt_q;
    logic             gnt;
    logic [IDXW-1:0]  word_idx;
    logic [MW-1:0]    mem_idx;
    logic             in_range;

    logic             rvalid_q;
    logic [DW-1:0]    rdata_q;
    logic             err_q;

    assign word_idx = obi_req_i.addr[`OBI_ADDR_WIDTH-1:OFFW];
    assign mem_idx  = word_idx[MW-1:0];
    assign in_range = (word_idx < IDXW'(`OBI_MEM_WORDS));

    // grant once req has waited the configured cycles
    assign gnt = obi_req_i.req && (wait_cnt_q == CW'(`OBI_GNT_WAIT));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt_q <= '0;
        end else if (obi_req_i.req && !gnt) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end else begin
            wait_cnt_q <= '0;
        end
    end

    // byte-enabled write on grant
    always_ff @(posedge clk) begin
        if (gnt && obi_req_i.we && in_range) begin
            for (int i = 0; i < BEW; i++) begin
                if (obi_req_i.be[i]) begin
                    mem[mem_idx][i*8 +: 8] <= obi_req_i.wdata[i*8 +: 8];
                end
            end
        end
    end

    // rvalid one cycle after gnt
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= gnt;
        end
    end

    // read data and error, zero data for writes and bad addresses
    always_ff @(posedge clk) begin
        if (gnt) begin
            err_q   <= !in_range;
            rdata_q <= (in_range && !obi_req_i.we) ? mem[mem_idx] : '0;
        end
    end

    assign obi_rsp_o.gnt    = gnt;
    assign obi_rsp_o.rvalid = rvalid_q;
    assign obi_rsp_o.rdata  = rdata_q;
    assign obi_rsp_o.err    = err_q;

endmodule

//--- obi/obi_master.sv
// obi master, single outstanding

`timescale 1ns/1ps
`include "obi_config.svh"

module obi_master (
    input  logic                        clk,
    input  logic                        rst_n,
    // request from the alignment unit
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  lsu_pkg::bus_req_t           req_i,
    // obi bus
    output obi_pkg::obi_req_t           obi_req_o,
    input  obi_pkg::obi_rsp_t           obi_rsp_i,
    // response back, no back-pressure
    output logic                        rsp_valid_o,
    output logic [`OBI_DATA_WIDTH-1:0]  rsp_rdata_o,
    output logic                        rsp_err_o
);

    obi_pkg::obi_state_e  state_q;
    obi_pkg::obi_state_e  state_d;

    // held payload, stable for the whole address phase
    lsu_pkg::bus_req_t    hold_q;

    logic                 accept;

    // only idle can take a new request
    assign req_ready_o = (state_q == obi_pkg::OBI_IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            obi_pkg::OBI_IDLE: begin
                if (accept) begin
                    state_d = obi_pkg::OBI_REQUESTING;
                end
            end
            obi_pkg::OBI_REQUESTING: begin
                // address phase done on gnt
                if (obi_rsp_i.gnt) begin
                    state_d = obi_pkg::OBI_WAITING;
                end
            end
            obi_pkg::OBI_WAITING: begin
                if (obi_rsp_i.rvalid) begin
                    state_d = obi_pkg::OBI_IDLE;
                end
            end
            default: begin
                state_d = obi_pkg::OBI_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= obi_pkg::OBI_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the request on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_q <= req_i;
        end
    end

    // req high only in requesting, drops the cycle after gnt
    assign obi_req_o.req   = (state_q == obi_pkg::OBI_REQUESTING);
    assign obi_req_o.addr  = hold_q.addr;
    assign obi_req_o.we    = hold_q.we;
    assign obi_req_o.be    = hold_q.be;
    assign obi_req_o.wdata = hold_q.wdata;

    // response passed straight through while waiting
    assign rsp_valid_o = (state_q == obi_pkg::OBI_WAITING) && obi_rsp_i.rvalid;
    assign rsp_rdata_o = obi_rsp_i.rdata;
    assign rsp_err_o   = obi_rsp_i.err;

endmodule

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_top -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/tb_clkgen.sv
// testbench clock and reset

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    // free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held low for the first few rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- tb/tb_top.sv
// load/store subsystem testbench

`timescale 1ns/1ps
`include "obi_config.svh"

module tb_top;

    // short names for the table
    localparam lsu_pkg::lsu_op_e   LD = lsu_pkg::LSU_LOAD;
    localparam lsu_pkg::lsu_op_e   ST = lsu_pkg::LSU_STORE;
    localparam lsu_pkg::lsu_size_e B  = lsu_pkg::LSU_BYTE;
    localparam lsu_pkg::lsu_size_e H  = lsu_pkg::LSU_HALF;
    localparam lsu_pkg::lsu_size_e W  = lsu_pkg::LSU_WORD;

    // one table row with its request and expected response
    typedef struct packed {
        lsu_pkg::lsu_op_e               op;
        lsu_pkg::lsu_size_e             size;
        logic                           is_unsigned;
        logic [`OBI_ADDR_WIDTH-1:0]     addr;
        logic [`OBI_DATA_WIDTH-1:0]     wdata;
        logic [`OBI_DATA_WIDTH-1:0]     exp_rdata;
        logic                           exp_err;
    } vec_t;

    logic               clk;
    logic               rst_n;
    logic               core_valid;
    logic               core_ready;
    lsu_pkg::lsu_req_t  core_req;
    logic               core_rsp_valid;
    lsu_pkg::lsu_rsp_t  core_rsp;

    vec_t               vec_q[$];
    int                 cycle_cnt = 0;
    int                 limit;

    tb_clkgen #(.PERIOD_NS(10), .RESET_CYCLES(3)) u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    obi_subsys_top obi_subsys_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .core_valid_i     (core_valid),
        .core_ready_o     (core_ready),
        .core_req_i       (core_req),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_o       (core_rsp)
    );

    function automatic void add_vector(input lsu_pkg::lsu_op_e op,
                                       input lsu_pkg::lsu_size_e size,
                                       input logic uns,
                                       input logic [`OBI_ADDR_WIDTH-1:0] addr,
                                       input logic [`OBI_DATA_WIDTH-1:0] wdata,
                                       input logic [`OBI_DATA_WIDTH-1:0] exp_rdata,
                                       input logic exp_err);
        vec_t v;
        v.op          = op;
        v.size        = size;
        v.is_unsigned = uns;
        v.addr        = addr;
        v.wdata       = wdata;
        v.exp_rdata   = exp_rdata;
        v.exp_err     = exp_err;
        vec_q.push_back(v);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic void fill_table();
        // word store and read back
        add_vector(ST, W, 1'b0, 32'h010, 32'hdead_beef, 32'h0, 1'b0);
        add_vector(LD, W, 1'b0, 32'h010, 32'h0, 32'hdead_beef, 1'b0);
        // bytes land in little-endian lane order
        add_vector(ST, B, 1'b0, 32'h020, 32'h11, 32'h0, 1'b0);
        add_vector(ST, B, 1'b0, 32'h021, 32'h22, 32'h0, 1'b0);
        add_vector(ST, B, 1'b0, 32'h022, 32'h33, 32'h0, 1'b0);
        add_vector(ST, B, 1'b0, 32'h023, 32'h44, 32'h0, 1'b0);
        add_vector(LD, W, 1'b0, 32'h020, 32'h0, 32'h4433_2211, 1'b0);
        // sign and zero extension with the top bit set in every byte lane
        add_vector(ST, W, 1'b0, 32'h030, 32'h9abc_80f0, 32'h0, 1'b0);
        add_vector(LD, H, 1'b0, 32'h030, 32'h0, 32'hffff_80f0, 1'b0);
        add_vector(LD, H, 1'b1, 32'h030, 32'h0, 32'h0000_80f0, 1'b0);
        add_vector(LD, H, 1'b0, 32'h032, 32'h0, 32'hffff_9abc, 1'b0);
        add_vector(LD, B, 1'b0, 32'h030, 32'h0, 32'hffff_fff0, 1'b0);
        add_vector(LD, B, 1'b1, 32'h030, 32'h0, 32'h0000_00f0, 1'b0);
        add_vector(LD, B, 1'b0, 32'h033, 32'h0, 32'hffff_ff9a, 1'b0);
        add_vector(LD, B, 1'b1, 32'h031, 32'h0, 32'h0000_0080, 1'b0);
        // upper half store keeps the lower lanes
        add_vector(ST, H, 1'b0, 32'h012, 32'h5566, 32'h0, 1'b0);
        add_vector(LD, W, 1'b0, 32'h010, 32'h0, 32'h5566_beef, 1'b0);
        // misaligned accesses are rejected without touching memory
        add_vector(ST, H, 1'b0, 32'h011, 32'h7777, 32'h0, 1'b1);
        add_vector(ST, W, 1'b0, 32'h012, 32'hcafe_f00d, 32'h0, 1'b1);
        add_vector(LD, H, 1'b0, 32'h023, 32'h0, 32'h0, 1'b1);
        add_vector(LD, W, 1'b0, 32'h021, 32'h0, 32'h0, 1'b1);
        add_vector(LD, W, 1'b0, 32'h010, 32'h0, 32'h5566_beef, 1'b0);
        // 0x404 is past the end and would alias word 1 if written
        add_vector(ST, W, 1'b0, 32'h004, 32'h1357_9bdf, 32'h0, 1'b0);
        add_vector(ST, W, 1'b0, 32'h404, 32'hffff_ffff, 32'h0, 1'b1);
        add_vector(LD, W, 1'b0, 32'h004, 32'h0, 32'h1357_9bdf, 1'b0);
        add_vector(LD, W, 1'b0, 32'h400, 32'h0, 32'h0, 1'b1);
        // last word still valid
        add_vector(ST, W, 1'b0, 32'h3fc, 32'h0bad_f00d, 32'h0, 1'b0);
        add_vector(LD, W, 1'b0, 32'h3fc, 32'h0, 32'h0bad_f00d, 1'b0);
        add_vector(LD, W, 1'b0, 32'h8000_0000, 32'h0, 32'h0, 1'b1);
    endfunction

    // drive one row and wait for acceptance and the response
    task automatic run_vector(input int idx);
        vec_t v;
        logic misaligned;
        v = vec_q[idx];
        misaligned = (v.size == H && v.addr[0]) || (v.size == W && v.addr[1:0] != 2'b00);
        @(posedge clk);
        core_valid           <= 1'b1;
        core_req.op          <= v.op;
        core_req.size        <= v.size;
        core_req.is_unsigned <= v.is_unsigned;
        core_req.addr        <= v.addr;
        core_req.wdata       <= v.wdata;
        // hold until ready so it is accepted on the next rising edge
        @(negedge clk);
        while (!core_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        core_valid <= 1'b0;
        @(negedge clk);
        if (misaligned) begin
            // answered locally one cycle after acceptance
            check_value("core_rsp_valid_o", 32'd1, 32'(core_rsp_valid));
        end
        // no new request taken while the bus is busy
        while (!core_rsp_valid) begin
            check_value("core_ready_o", 32'd0, 32'(core_ready));
            @(negedge clk);
        end
        check_value("core_rsp_o.rdata", v.exp_rdata, core_rsp.rdata);
        check_value("core_rsp_o.err", 32'(v.exp_err), 32'(core_rsp.err));
    endtask

    // run limit from table length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    initial begin
        int gap;
        core_valid = 1'b0;
        core_req   = '0;
        void'($urandom(32'hc2a2_a5ad));
        fill_table();
        limit = vec_q.size() * (`OBI_GNT_WAIT + 8) + 50;
        @(posedge rst_n);
        @(negedge clk);
        check_value("core_ready_o", 32'd1, 32'(core_ready));
        check_value("core_rsp_valid_o", 32'd0, 32'(core_rsp_valid));
        for (int i = 0; i < vec_q.size(); i++) begin
            // every third request follows its predecessor back to back
            if (i % 3 == 0) begin
                gap = 0;
            end else begin
                gap = $urandom % 4;
            end
            repeat (gap) @(posedge clk);
            run_vector(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/obi_pkg.sv
common/lsu_pkg.sv
logic/lsu_align.sv
obi/obi_master.sv
mem/obi_sram.sv
logic/obi_subsys_top.sv
tb/tb_clkgen.sv
tb/tb_top.sv
